// ==== common/cart_pkg.sv ====
package cart_pkg;

  localparam int snes_addr_w = 24;  // Console byte address
  localparam int rom_addr_w  = 23;  // 16-bit word address into ROM/PSRAM

  typedef logic [7:0] byte_t;

  // Console control lines, all active as on the cartridge edge
  typedef struct packed {
    logic rd_n;
    logic wr_n;
    logic cpu_clk;
    logic romsel_n;
  } snes_ctl_t;

  typedef struct packed {
    logic [snes_addr_w-1:0] addr;
    byte_t                  data;
    snes_ctl_t              ctl;
  } snes_bus_t;

  // Strobes last one CLK2 cycle, dead is a level
  typedef struct packed {
    logic cycle_start;
    logic cycle_end;
    logic rd_start;
    logic rd_end;
    logic wr_end;
    logic free_slot;
    logic reset_strobe;
    logic dead;
  } snes_events_t;

  typedef struct packed {
    logic                   rrq;
    logic                   wrq;
    logic [snes_addr_w-1:0] addr;
    byte_t                  wdata;
  } mcu_req_t;

  typedef enum logic [4:0] {
    idle    = 5'b00001,
    rd_addr = 5'b00010,
    rd_end  = 5'b00100,
    wr_addr = 5'b01000,
    wr_end  = 5'b10000
  } arb_state_t;

  typedef struct packed {
    logic [rom_addr_w-1:0] addr;
    logic [15:0]           wdata;
    logic                  data_oe;  // Cart drives ROM data pins
    logic                  we_n;
    logic                  bhe_n;
    logic                  ble_n;
  } rom_bus_t;

endpackage

// ==== snes_bus/bus_sync.sv ====
`timescale 1ns/10ps

// Shift-register synchronizer for one console payload
module bus_sync #(
  parameter type payload_t = logic,
  parameter int  depth     = 2
) (
  input  logic                 CLK2,
  input  payload_t             raw,
  output payload_t             filt,
  output payload_t [7:0]       hist
);

  // Chain is at least eight long so hist always has real samples
  localparam int len = (depth > 8) ? depth : 8;

  payload_t [len-1:0] chain;  // [0] is the newest sample

  always_ff @(posedge CLK2) begin
    chain <= {chain[len-2:0], raw};
  end

  // Two late stages must agree on a 1, single-sample glitches drop out
  assign filt = payload_t'(chain[depth-1] & chain[depth-2]);

  assign hist = chain[7:0];

endmodule

// ==== snes_bus/bus_events.sv ====
`timescale 1ns/10ps

module bus_events import cart_pkg::*; #(
  parameter int unsigned dead_timeout = 86400
) (
  input  logic                CLK2,
  input  logic                rst_n,
  input  snes_ctl_t [7:0]     ctl_hist,
  input  logic                rom_hit,
  output snes_events_t        ev
);

  localparam int cnt_w = $clog2(dead_timeout + 2);

  logic [7:0]       rd_h;
  logic [7:0]       wr_h;
  logic [7:0]       clk_h;
  logic             cyc_start_q;
  logic             cyc_end_q;
  logic             rd_start_q;
  logic             rd_end_q;
  logic             wr_end_q;
  logic             free_strobe_q;
  logic             reset_strobe_q;
  logic             dead_q;
  logic [cnt_w-1:0] dead_cnt;

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      rd_h[i]  = ctl_hist[i].rd_n;
      wr_h[i]  = ctl_hist[i].wr_n;
      clk_h[i] = ctl_hist[i].cpu_clk;
    end
  end

  ////////////////////////////////////////
  // Edge strobes, an edge needs a stable run on both sides
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      cyc_start_q   <= 1'b0;
      cyc_end_q     <= 1'b0;
      rd_start_q    <= 1'b0;
      rd_end_q      <= 1'b0;
      wr_end_q      <= 1'b0;
      free_strobe_q <= 1'b0;
    end else begin
      cyc_start_q   <= ((clk_h[7:2] & clk_h[6:1]) == 6'b000011);
      cyc_end_q     <= ((clk_h[7:2] | clk_h[6:1]) == 6'b111000);
      rd_start_q    <= ((rd_h[6:1] | rd_h[7:2]) == 6'b111100);
      rd_end_q      <= ((rd_h[6:1] & rd_h[7:2]) == 6'b000001);
      wr_end_q      <= ((wr_h[6:1] & wr_h[7:2]) == 6'b000001);
      free_strobe_q <= cyc_start_q & ~rom_hit;  // Console not on ROM this cycle
    end
  end

  ////////////////////////////////////////
  // Dead console watchdog
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      dead_cnt       <= '0;
      dead_q         <= 1'b1;
      reset_strobe_q <= 1'b0;
    end else begin
      reset_strobe_q <= 1'b0;
      if (clk_h[1]) begin
        dead_cnt       <= '0;
        dead_q         <= 1'b0;
        reset_strobe_q <= dead_q;  // Clock came back
      end else begin
        if (dead_cnt <= cnt_w'(dead_timeout))
          dead_cnt <= dead_cnt + 1'b1;  // Saturates just past timeout
        if (dead_cnt > cnt_w'(dead_timeout))
          dead_q <= 1'b1;
      end
    end
  end

  assign ev = '{
    cycle_start:  cyc_start_q,
    cycle_end:    cyc_end_q,
    rd_start:     rd_start_q,
    rd_end:       rd_end_q,
    wr_end:       wr_end_q,
    free_slot:    cyc_end_q | free_strobe_q,
    reset_strobe: reset_strobe_q,
    dead:         dead_q
  };

endmodule

// ==== mcu_port/mcu_arbiter.sv ====
`timescale 1ns/10ps

module mcu_arbiter import cart_pkg::*; #(
  parameter int unsigned rom_cycle_len = 7
) (
  input  logic                   CLK2,
  input  logic                   rst_n,
  input  mcu_req_t               req,
  input  snes_events_t           ev,
  input  logic [15:0]            rom_rdata,
  output arb_state_t             state,
  output logic [snes_addr_w-1:0] mcu_addr_q,
  output byte_t                  mcu_wdata_q,
  output byte_t                  mcu_rdata,
  output logic                   mcu_rdy
);

  localparam int dly_w = (rom_cycle_len > 0) ? $clog2(rom_cycle_len + 1) : 1;

  logic             rd_pend;
  logic             wr_pend;
  logic             done;
  logic [dly_w-1:0] dly;  // Window countdown

  assign done = (state == rd_end) || (state == wr_end);

  ////////////////////////////////////////
  // Request latch and ready flag
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (req.rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (req.wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (done) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;  // Rises the cycle after the end state
    end
  end

  always_ff @(posedge CLK2) begin
    if (req.rrq || req.wrq)
      mcu_addr_q <= req.addr;
    if (req.wrq)
      mcu_wdata_q <= req.wdata;
  end

  ////////////////////////////////////////
  // Access FSM
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      state <= idle;
      dly   <= '0;
    end else if (ev.reset_strobe) begin
      // Console woke up mid access, start over from idle
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (ev.free_slot || ev.dead) begin
            if (rd_pend) begin
              state <= rd_addr;
              dly   <= dly_w'(rom_cycle_len);
            end else if (wr_pend) begin
              state <= wr_addr;
              dly   <= dly_w'(rom_cycle_len);
            end
          end
        end
        rd_addr: begin
          dly <= dly - 1'b1;
          if (dly == '0)
            state <= rd_end;
        end
        wr_addr: begin
          dly <= dly - 1'b1;
          if (dly == '0)
            state <= wr_end;
        end
        default: state <= idle;  // Both end states last one cycle
      endcase
    end
  end

  // Last sample of the window wins, addr bit 0 set picks the low byte
  always_ff @(posedge CLK2) begin
    if (state == rd_addr)
      mcu_rdata <= mcu_addr_q[0] ? rom_rdata[7:0] : rom_rdata[15:8];
  end

endmodule

// ==== design/rom_port_mux.sv ====
`timescale 1ns/10ps

module rom_port_mux import cart_pkg::*; (
  input  snes_bus_t              snes,
  input  logic [snes_addr_w-1:0] rom_mask,
  input  arb_state_t             state,
  input  logic [snes_addr_w-1:0] mcu_addr_q,
  input  byte_t                  mcu_wdata_q,
  input  logic [15:0]            rom_rdata,
  output rom_bus_t               rom,
  output logic                   rom_hit,
  output byte_t                  snes_rdata,
  output logic                   snes_data_dir
);

  logic [snes_addr_w-1:0] mapped_addr;
  logic [snes_addr_w-1:0] sel_addr;
  logic                   mcu_hit;
  logic                   wr_hit;
  logic                   addr0;  // Byte lane select

  ////////////////////////////////////////
  // Address mapping and selection
  assign mapped_addr = snes.addr & rom_mask;
  assign rom_hit     = ~snes.ctl.romsel_n;

  assign mcu_hit = (state == rd_addr) || (state == wr_addr);
  assign wr_hit  = (state == wr_addr);

  assign sel_addr = mcu_hit ? mcu_addr_q : mapped_addr;
  assign addr0    = sel_addr[0];

  ////////////////////////////////////////
  // ROM drive
  always_comb begin
    rom.addr    = sel_addr[snes_addr_w-1:1];  // Byte to word address
    rom.data_oe = wr_hit;
    rom.we_n    = ~wr_hit;
    rom.bhe_n   = addr0;
    rom.ble_n   = ~addr0;
    // Write byte only on the enabled lane
    if (addr0)
      rom.wdata = {8'h00, mcu_wdata_q};
    else
      rom.wdata = {mcu_wdata_q, 8'h00};
  end

  // Console read side
  assign snes_rdata    = addr0 ? rom_rdata[7:0] : rom_rdata[15:8];
  assign snes_data_dir = ~snes.ctl.rd_n;  // Drive toward console on reads

endmodule

// ==== design/cart_main.sv ====
`timescale 1ns/10ps

module cart_main import cart_pkg::*; #(
  parameter int unsigned dead_timeout  = 86400,
  parameter int unsigned rom_cycle_len = 7
) (
  input  logic                   CLK2,
  input  logic                   rst_n,
  input  snes_bus_t              snes_in,
  input  mcu_req_t               mcu_req,
  input  logic [snes_addr_w-1:0] rom_mask,
  input  logic [15:0]            rom_rdata,
  output rom_bus_t               rom,
  output byte_t                  snes_rdata,
  output logic                   snes_data_dir,
  output byte_t                  mcu_rdata,
  output logic                   mcu_rdy
);

  snes_ctl_t              sync_ctl;
  logic [snes_addr_w-1:0] sync_addr;
  byte_t                  sync_data;
  snes_ctl_t [7:0]        ctl_hist;
  snes_bus_t              snes_s;
  snes_events_t           ev;
  arb_state_t             state;
  logic [snes_addr_w-1:0] mcu_addr_q;
  byte_t                  mcu_wdata_q;
  logic                   rom_hit;

  ////////////////////////////////////////
  // Console input synchronizers
  bus_sync #(.payload_t(snes_ctl_t), .depth(8)) ctl_sync_i (
    .CLK2 (CLK2),
    .raw  (snes_in.ctl),
    .filt (sync_ctl),
    .hist (ctl_hist)
  );

  bus_sync #(.payload_t(logic [snes_addr_w-1:0]), .depth(7)) addr_sync_i (
    .CLK2 (CLK2),
    .raw  (snes_in.addr),
    .filt (sync_addr),
    .hist ()
  );

  bus_sync #(.payload_t(byte_t), .depth(5)) data_sync_i (
    .CLK2 (CLK2),
    .raw  (snes_in.data),
    .filt (sync_data),
    .hist ()
  );

  assign snes_s = '{addr: sync_addr, data: sync_data, ctl: sync_ctl};

  bus_events #(.dead_timeout(dead_timeout)) bus_events_i (
    .CLK2     (CLK2),
    .rst_n    (rst_n),
    .ctl_hist (ctl_hist),
    .rom_hit  (rom_hit),
    .ev       (ev)
  );

  ////////////////////////////////////////
  // MCU side and ROM port
  mcu_arbiter #(.rom_cycle_len(rom_cycle_len)) mcu_arbiter_i (
    .CLK2        (CLK2),
    .rst_n       (rst_n),
    .req         (mcu_req),
    .ev          (ev),
    .rom_rdata   (rom_rdata),
    .state       (state),
    .mcu_addr_q  (mcu_addr_q),
    .mcu_wdata_q (mcu_wdata_q),
    .mcu_rdata   (mcu_rdata),
    .mcu_rdy     (mcu_rdy)
  );

  rom_port_mux rom_port_mux_i (
    .snes          (snes_s),
    .rom_mask      (rom_mask),
    .state         (state),
    .mcu_addr_q    (mcu_addr_q),
    .mcu_wdata_q   (mcu_wdata_q),
    .rom_rdata     (rom_rdata),
    .rom           (rom),
    .rom_hit       (rom_hit),
    .snes_rdata    (snes_rdata),
    .snes_data_dir (snes_data_dir)
  );

endmodule

// ==== sim/cart_main_assert.sv ====
`timescale 1ns/10ps

module cart_main_assert import cart_pkg::*; (
  input logic                   CLK2,
  input logic                   rst_n,
  input mcu_req_t               req,
  input arb_state_t             state,
  input logic [snes_addr_w-1:0] mcu_addr_q,
  input logic                   mcu_rdy,
  input rom_bus_t               rom
);

  int fail_cnt = 0;  // Assertion failures so far

  // Ready must drop right after a request pulse
  req_lowers_rdy: assert property (@(posedge CLK2) disable iff (!rst_n)
    (req.rrq || req.wrq) |=> !mcu_rdy)
    else begin
      $error("mcu_rdy still high one cycle after a request pulse");
      fail_cnt++;
    end

  write_in_window: assert property (@(posedge CLK2) disable iff (!rst_n)
    !rom.we_n |-> (state == wr_addr))
    else begin
      $error("ROM we_n low outside the write window");
      fail_cnt++;
    end

  // Inside a window the ROM word and lane follow the latched MCU address
  mcu_addr_on_rom: assert property (@(posedge CLK2) disable iff (!rst_n)
    (state == rd_addr || state == wr_addr) |->
      ({rom.addr, rom.bhe_n, !rom.ble_n} == {mcu_addr_q, mcu_addr_q[0]}))
    else begin
      $error("ROM address or byte lane does not follow the MCU address");
      fail_cnt++;
    end

endmodule

bind cart_main cart_main_assert cart_main_assert_i (
  .CLK2       (CLK2),
  .rst_n      (rst_n),
  .req        (mcu_req),
  .state      (state),
  .mcu_addr_q (mcu_addr_q),
  .mcu_rdy    (mcu_rdy),
  .rom        (rom)
);

// ==== sim/clk_gen.sv ====
`timescale 1ns/10ps

// Testbench clock, 8 ns period, reset held low for three cycles
module clk_gen (
  output logic CLK2,
  output logic rst_n
);

  initial begin
    CLK2 = 1'b0;
    forever #4 CLK2 = ~CLK2;
  end

  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge CLK2);
    @(negedge CLK2);  // Release away from the sampling edge
    rst_n = 1'b1;
  end

endmodule

// ==== sim/tb_cart_main.sv ====
`timescale 1ns/10ps

module tb_cart_main import cart_pkg::*; ();

  localparam int mem_words = 4096;  // 13-bit byte address space in the model

  logic        CLK2;
  logic        rst_n;
  logic [23:0] s_addr;
  byte_t       s_data;
  logic        rd_n;
  logic        wr_n;
  logic        cpu_clk;
  logic        romsel_n;
  snes_bus_t   snes_in;
  mcu_req_t    mcu_req;
  logic [23:0] rom_mask;
  logic [15:0] rom_rdata;
  rom_bus_t    rom;
  byte_t       snes_rdata;
  byte_t       mcu_rdata;
  logic        snes_data_dir;
  logic        mcu_rdy;
  logic [15:0] mem [mem_words];
  byte_t       shadow [2*mem_words];  // Expected ROM contents, per byte
  logic [31:0] seed = 32'h70ce;
  logic        cpu_run;
  int          cpu_cnt;
  logic [8:0]  mcu_exp_q [$];  // {is_read, byte}
  byte_t       snes_exp_q [$];
  logic        snes_chk;
  logic        rdy_prev;
  int          checks;
  int          errors;

  assign snes_in = '{addr: s_addr, data: s_data,
                     ctl: '{rd_n: rd_n, wr_n: wr_n, cpu_clk: cpu_clk, romsel_n: romsel_n}};

  clk_gen clk_gen_i (.CLK2(CLK2), .rst_n(rst_n));

  cart_main #(.dead_timeout(64)) cart_main_i (
    .CLK2          (CLK2),
    .rst_n         (rst_n),
    .snes_in       (snes_in),
    .mcu_req       (mcu_req),
    .rom_mask      (rom_mask),
    .rom_rdata     (rom_rdata),
    .rom           (rom),
    .snes_rdata    (snes_rdata),
    .snes_data_dir (snes_data_dir),
    .mcu_rdata     (mcu_rdata),
    .mcu_rdy       (mcu_rdy)
  );

  ////////////////////////////////////////
  // ROM model
  assign rom_rdata = mem[rom.addr[11:0]];

  always @(posedge CLK2) begin
    if (rom.we_n === 1'b0) begin
      check_val("rom.data_oe", rom.data_oe, 1);  // Cart drives data while writing
      if (!rom.ble_n) mem[rom.addr[11:0]][7:0] <= rom.wdata[7:0];
      if (!rom.bhe_n) mem[rom.addr[11:0]][15:8] <= rom.wdata[15:8];
    end
  end

  function automatic logic [15:0] fill_word(input int unsigned i);
    logic [31:0] h;
    h = i * 32'h9e3779b1;
    return h[31:16] ^ 16'(i);
  endfunction

  // Even byte address sits in the high lane, odd in the low lane
  function automatic byte_t ref_byte(input logic [23:0] baddr);
    return shadow[baddr[12:0]];
  endfunction

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = lcg(seed);
    return seed;
  endfunction

  // Console CPU clock, 12 CLK2 cycles per period
  always @(negedge CLK2) begin
    if (cpu_run) begin
      if (cpu_cnt == 5) begin
        cpu_cnt = 0;
        cpu_clk = ~cpu_clk;
      end else
        cpu_cnt = cpu_cnt + 1;
    end
  end

  task automatic check_val(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, actual, expected);
    end
  endtask

  ////////////////////////////////////////
  // Compare process, samples before the edge updates
  always @(posedge CLK2) begin
    logic [8:0] e;
    if (rst_n === 1'b1) begin
      if (mcu_rdy && !rdy_prev && mcu_exp_q.size() > 0) begin
        e = mcu_exp_q.pop_front();
        if (e[8]) check_val("mcu_rdata", mcu_rdata, e[7:0]);
      end
      if (snes_chk && snes_exp_q.size() > 0) begin
        check_val("snes_rdata", snes_rdata, snes_exp_q.pop_front());
        check_val("snes_data_dir", snes_data_dir, 1);
      end
    end
    rdy_prev = mcu_rdy;
  end

  task automatic wait_rdy(input logic level, input int limit, output bit ok);
    int n;
    n = 0;
    while (mcu_rdy !== level && n < limit) begin
      @(negedge CLK2);
      n++;
    end
    ok = (mcu_rdy === level);
    if (!ok) begin
      errors++;
      $display("mcu_rdy did not go to %0b within %0d cycles at %0t", level, limit, $time);
    end
  endtask

  // One MCU access from pulse to completion
  task automatic mcu_access(input bit wr, input logic [23:0] a, input byte_t d);
    bit ok;
    mcu_req.addr  = a;
    mcu_req.wdata = d;
    if (wr) begin
      mcu_req.wrq = 1'b1;
      shadow[a[12:0]] = d;
      mcu_exp_q.push_back({1'b0, d});
    end else begin
      mcu_req.rrq = 1'b1;
      mcu_exp_q.push_back({1'b1, ref_byte(a)});
    end
    @(negedge CLK2);
    mcu_req.rrq = 1'b0;
    mcu_req.wrq = 1'b0;
    wait_rdy(1'b0, 2, ok);
    if (ok) wait_rdy(1'b1, 400, ok);
    if (!ok) mcu_exp_q.delete();
  endtask

  task automatic end_test(input string name, input int err_before);
    $display("test %s finished with %0d errors", name, errors - err_before);
  endtask

  initial begin
    int          err0;
    int          n;
    int          afail;
    logic [23:0] a;
    logic [31:0] r;
    logic [15:0] w;
    s_addr   = '0;
    s_data   = '0;
    rd_n     = 1'b1;
    wr_n     = 1'b1;
    cpu_clk  = 1'b0;
    romsel_n = 1'b1;
    mcu_req  = '0;
    rom_mask = 24'h001fff;
    cpu_run  = 1'b0;
    cpu_cnt  = 0;
    snes_chk = 1'b0;
    rdy_prev = 1'b1;
    checks   = 0;
    errors   = 0;
    for (int i = 0; i < mem_words; i++) begin
      w              = fill_word(i);
      mem[i]        <= w;
      shadow[2*i]    = w[15:8];
      shadow[2*i+1]  = w[7:0];
    end

    err0 = errors;
    n = 0;
    while (rst_n !== 1'b1 && n < 20) begin
      @(negedge CLK2);
      n++;
    end
    if (rst_n !== 1'b1) begin
      errors++;
      $display("reset was never released");
    end
    @(negedge CLK2);
    check_val("mcu_rdy", mcu_rdy, 1);
    check_val("rom.we_n", rom.we_n, 1);
    check_val("rom.data_oe", rom.data_oe, 0);
    end_test("reset", err0);

    ////////////////////////////////////////
    // Dead console, MCU owns the ROM
    err0 = errors;
    repeat (110) @(negedge CLK2);
    for (int i = 0; i < 20; i++) begin
      r = next_rand();
      mcu_access(1'b0, {11'h0, r[28:16]}, 8'h00);
    end
    end_test("mcu read, console dead", err0);

    err0 = errors;
    for (int i = 0; i < 10; i++) begin
      r = next_rand();
      a = {11'h0, r[28:16]};
      r = next_rand();
      mcu_access(1'b1, a, r[23:16]);
      mcu_access(1'b0, a, 8'h00);
      mcu_access(1'b0, a ^ 24'h1, 8'h00);  // Other lane untouched
    end
    end_test("mcu write, console dead", err0);

    ////////////////////////////////////////
    // Console alive
    err0 = errors;
    cpu_run = 1'b1;
    repeat (30) @(negedge CLK2);
    for (int i = 0; i < 8; i++) begin
      r        = next_rand();
      a        = r[31:8];
      s_addr   = a;
      romsel_n = 1'b0;
      rd_n     = 1'b0;
      repeat (15) @(negedge CLK2);
      snes_exp_q.push_back(ref_byte(a & rom_mask));
      snes_chk = 1'b1;
      @(negedge CLK2);
      snes_chk = 1'b0;
      rd_n     = 1'b1;
      romsel_n = 1'b1;
      repeat (4) @(negedge CLK2);
    end
    end_test("console rom read", err0);

    err0 = errors;
    r        = next_rand();
    s_addr   = r[31:8];
    romsel_n = 1'b0;
    rd_n     = 1'b0;
    for (int i = 0; i < 6; i++) begin
      r = next_rand();
      mcu_access(1'b0, {11'h0, r[28:16]}, 8'h00);
    end
    rd_n     = 1'b1;
    romsel_n = 1'b1;
    end_test("mcu read, console alive", err0);

    repeat (4) @(negedge CLK2);
    if (mcu_exp_q.size() != 0 || snes_exp_q.size() != 0) begin
      errors++;
      $display("some expected results were never compared");
    end
    afail = cart_main_i.cart_main_assert_i.fail_cnt;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, afail);
    if (errors == 0 && afail == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== sources.f ====
common/cart_pkg.sv
snes_bus/bus_sync.sv
snes_bus/bus_events.sv
mcu_port/mcu_arbiter.sv
design/rom_port_mux.sv
design/cart_main.sv
sim/cart_main_assert.sv
sim/clk_gen.sv
sim/tb_cart_main.sv

// ==== Bender.yml ====
package:
  name: cart_main

sources:
  - common/cart_pkg.sv
  - snes_bus/bus_sync.sv
  - snes_bus/bus_events.sv
  - mcu_port/mcu_arbiter.sv
  - design/rom_port_mux.sv
  - design/cart_main.sv
  - target: simulation
    files:
      - sim/cart_main_assert.sv
      - sim/clk_gen.sv
      - sim/tb_cart_main.sv
